//--- sources.f
+incdir+hw
hw/iq_pkg.sv
hw/iq_dispatch.sv
hw/iq_circ_buf.sv
hw/iq_issue_select.sv
hw/iq_top.sv
verification/iq_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instruction queue testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module iq_tb -o iq_sim

out=$(./obj_dir/iq_sim)
echo "$out"

if echo "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

//--- verification/iq_tb.sv
`timescale 1ns/10ps
`include "iq_params.svh"

module iq_tb
  import iq_pkg::*;
();

  localparam int INS        = `IQ_INS_COUNT;
  localparam int EXT        = `IQ_EXT_COUNT;
  localparam int DEPTH      = `IQ_DEPTH;
  localparam int NUM_ROWS   = 19;
  localparam int CLK_PERIOD = 20;

  localparam logic [31:0] I_ALU    = 32'h0010_0093;
  localparam logic [31:0] I_LOAD   = 32'h0000_2103;
  localparam logic [31:0] I_STORE  = 32'h0020_2023;
  localparam logic [31:0] I_BRANCH = 32'h0020_8463;

  // one cycle of stimulus; lane 0 sits in the low bits of inst and stream.
  typedef struct packed {
    logic             en;
    logic [1:0]       cnt;
    logic [3:0][31:0] inst;
    logic [3:0]       stream;
    logic             flush;
    logic             fstream;
    logic [2:0]       exp_issue;
    logic             exp_stall;
  } row_t;

  logic                        clock;
  logic                        reset_n;
  logic                        dec_enable;
  logic [$clog2(INS)-1:0]      dec_count;
  logic [31:0]                 dec_pc [INS];
  logic [31:0]                 dec_inst [INS];
  logic                        dec_stream [INS];
  logic                        flush;
  logic                        flush_stream;
  logic                        stall;
  logic                        empty;
  logic                        issue_valid [EXT];
  iq_entry_t                   issue_entry [EXT];

  row_t                        rows [$];
  iq_entry_t                   model_q [$];   // expected queue contents, oldest first.
  logic [ROB_SLOT_W-1:0]       model_slot;
  int                          pc_idx;
  int                          errors;
  int                          checks;

  iq_top i_dut (
    .clock          (clock),
    .reset_n        (reset_n),
    .dec_enable_i   (dec_enable),
    .dec_count_i    (dec_count),
    .dec_pc_i       (dec_pc),
    .dec_inst_i     (dec_inst),
    .dec_stream_i   (dec_stream),
    .flush_i        (flush),
    .flush_stream_i (flush_stream),
    .stall_o        (stall),
    .empty_o        (empty),
    .issue_valid_o  (issue_valid),
    .issue_entry_o  (issue_entry)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #((NUM_ROWS + 4) * CLK_PERIOD + 200);
    $display("timeout, the stimulus table did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic op_class_e class_of(input logic [31:0] inst);
    case (inst[6:0])
      7'b0000011: return OP_LOAD;
      7'b0100011: return OP_STORE;
      7'b1100011: return OP_BRANCH;
      default:    return OP_ALU;
    endcase
  endfunction

  function automatic logic [31:0] pc_of(input int idx);
    return 32'h0000_1000 + 32'(idx) * 32'd4;
  endfunction

  // lanes the model issues from its head under the grouping rules.
  function automatic int model_issue_count();
    int  n;
    bit  mem_seen;
    bit  is_mem;
    n        = 0;
    mem_seen = 1'b0;
    for (int i = 0; i < EXT && i < model_q.size(); i++) begin
      is_mem = (model_q[i].op == OP_LOAD) || (model_q[i].op == OP_STORE);
      if (is_mem && mem_seen)
        break;
      n++;
      mem_seen = mem_seen | is_mem;
      if (model_q[i].op == OP_BRANCH)
        break;
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic en, input logic [1:0] cnt, input logic [31:0] w0,
                         input logic [31:0] w1, input logic [31:0] w2, input logic [31:0] w3,
                         input logic [3:0] s, input logic fl, input logic fs,
                         input logic [2:0] n, input logic st);
    row_t r;
    r.en        = en;
    r.cnt       = cnt;
    r.inst      = {w3, w2, w1, w0};
    r.stream    = s;
    r.flush     = fl;
    r.fstream   = fs;
    r.exp_issue = n;
    r.exp_stall = st;
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 0, 0);
    add_row(1, 3, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 0, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 4, 0);
    add_row(1, 2, I_LOAD, I_ALU, I_STORE, I_ALU, 4'b0000, 0, 0, 0, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 2, 0);
    add_row(1, 3, I_ALU, I_BRANCH, I_ALU, I_ALU, 4'b0000, 0, 0, 1, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 2, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 2, 0);
    // branches issue one per cycle, so four-wide inserts fill the queue.
    add_row(1, 3, I_BRANCH, I_BRANCH, I_BRANCH, I_BRANCH, 4'b0000, 0, 0, 0, 0);
    add_row(1, 3, I_BRANCH, I_BRANCH, I_BRANCH, I_BRANCH, 4'b0000, 0, 0, 1, 0);
    add_row(1, 3, I_BRANCH, I_BRANCH, I_BRANCH, I_BRANCH, 4'b0000, 0, 0, 1, 0);
    add_row(1, 3, I_BRANCH, I_BRANCH, I_BRANCH, I_BRANCH, 4'b0000, 0, 0, 1, 0);
    add_row(1, 3, I_BRANCH, I_BRANCH, I_BRANCH, I_BRANCH, 4'b0000, 0, 0, 1, 1);
    add_row(1, 3, I_BRANCH, I_BRANCH, I_BRANCH, I_BRANCH, 4'b0000, 0, 0, 1, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 1, 0, 1, 1);  // clears stream 0.
    add_row(1, 3, I_BRANCH, I_BRANCH, I_ALU, I_ALU, 4'b1011, 0, 0, 0, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 1, 1, 1, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 2, 0);
    add_row(0, 0, I_ALU, I_ALU, I_ALU, I_ALU, 4'b0000, 0, 0, 0, 0);
  endtask

  // extract, then insert, then flush, as the queue does at each edge.
  task automatic update_model(input row_t r, input bit accept, input int n);
    iq_entry_t e;
    repeat (n) void'(model_q.pop_front());
    if (accept) begin
      for (int i = 0; i <= int'(r.cnt); i++) begin
        e.pc        = pc_of(pc_idx + i);
        e.inst_word = r.inst[i];
        e.rob_slot  = model_slot + ROB_SLOT_W'(i);
        e.stream    = r.stream[i];
        e.op        = class_of(r.inst[i]);
        model_q.push_back(e);
      end
      model_slot = model_slot + ROB_SLOT_W'(r.cnt) + ROB_SLOT_W'(1);
      pc_idx     = pc_idx + int'(r.cnt) + 1;
    end
    if (r.flush) begin
      while (model_q.size() > 0 && model_q[0].stream == r.fstream)
        void'(model_q.pop_front());
    end
  endtask

  initial begin
    int n_model;
    bit model_full;
    reset_n      = 1'b0;
    dec_enable   = 1'b0;
    dec_count    = '0;
    flush        = 1'b0;
    flush_stream = 1'b0;
    for (int i = 0; i < INS; i++) begin
      dec_pc[i]     = '0;
      dec_inst[i]   = '0;
      dec_stream[i] = 1'b0;
    end
    errors     = 0;
    checks     = 0;
    pc_idx     = 0;
    model_slot = '0;
    build_table();
    if (rows.size() != NUM_ROWS) begin
      errors++;
      $display("stimulus table holds %0d rows instead of %0d", rows.size(), NUM_ROWS);
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;

    foreach (rows[k]) begin
      @(negedge clock);
      dec_enable   = rows[k].en;
      dec_count    = rows[k].cnt;
      flush        = rows[k].flush;
      flush_stream = rows[k].fstream;
      for (int i = 0; i < INS; i++) begin
        dec_pc[i]     = pc_of(pc_idx + i);  // a held group keeps its pcs.
        dec_inst[i]   = rows[k].inst[i];
        dec_stream[i] = rows[k].stream[i];
      end
      #(CLK_PERIOD / 4);
      n_model    = model_issue_count();
      model_full = model_q.size() > (DEPTH - INS);
      check_value("model issue count", 32'(n_model), 32'(rows[k].exp_issue));
      check_value("model stall", 32'(model_full), 32'(rows[k].exp_stall));
      check_value("stall_o", 32'(stall), 32'(rows[k].exp_stall));
      check_value("empty_o", 32'(empty), 32'(model_q.size() == 0));
      for (int i = 0; i < EXT; i++) begin
        check_value($sformatf("issue_valid_o[%0d]", i), 32'(issue_valid[i]),
                    32'(i < int'(rows[k].exp_issue)));
        if (i < n_model) begin
          check_value($sformatf("issue_entry_o[%0d].pc", i), issue_entry[i].pc,
                      model_q[i].pc);
          check_value($sformatf("issue_entry_o[%0d].inst_word", i),
                      issue_entry[i].inst_word, model_q[i].inst_word);
          check_value($sformatf("issue_entry_o[%0d].rob_slot", i),
                      32'(issue_entry[i].rob_slot), 32'(model_q[i].rob_slot));
          check_value($sformatf("issue_entry_o[%0d].stream", i),
                      32'(issue_entry[i].stream), 32'(model_q[i].stream));
          check_value($sformatf("issue_entry_o[%0d].op", i), 32'(issue_entry[i].op),
                      32'(model_q[i].op));
        end
      end
      update_model(rows[k], rows[k].en && !model_full, n_model);
    end

    @(negedge clock);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- hw/iq_top.sv
`timescale 1ns/10ps
`include "iq_params.svh"

module iq_top
  import iq_pkg::*;
(
  input  logic                              clock,
  input  logic                              reset_n,
  input  logic                              dec_enable_i,
  input  logic [$clog2(`IQ_INS_COUNT)-1:0]  dec_count_i,
  input  logic [31:0]                       dec_pc_i [`IQ_INS_COUNT],
  input  logic [31:0]                       dec_inst_i [`IQ_INS_COUNT],
  input  logic                              dec_stream_i [`IQ_INS_COUNT],
  input  logic                              flush_i,
  input  logic                              flush_stream_i,
  output logic                              stall_o,
  output logic                              empty_o,
  output logic                              issue_valid_o [`IQ_EXT_COUNT],
  output iq_entry_t                         issue_entry_o [`IQ_EXT_COUNT]
);

  logic                              full;
  logic                              ins_enable;
  logic [$clog2(`IQ_INS_COUNT)-1:0]  new_count;
  iq_entry_t                         new_elements [`IQ_INS_COUNT];
  logic                              ext_valid [`IQ_EXT_COUNT];
  iq_entry_t                         out_elements [`IQ_EXT_COUNT];
  logic                              ext_enable;
  logic [$clog2(`IQ_EXT_COUNT)-1:0]  ext_consumed;

  iq_dispatch i_dispatch (
    .clock          (clock),
    .reset_n        (reset_n),
    .dec_enable_i   (dec_enable_i),
    .dec_count_i    (dec_count_i),
    .dec_pc_i       (dec_pc_i),
    .dec_inst_i     (dec_inst_i),
    .dec_stream_i   (dec_stream_i),
    .full_i         (full),
    .stall_o        (stall_o),
    .ins_enable_o   (ins_enable),
    .new_count_o    (new_count),
    .new_elements_o (new_elements)
  );

  iq_circ_buf i_circ_buf (
    .clock          (clock),
    .reset_n        (reset_n),
    .ins_enable_i   (ins_enable),
    .new_count_i    (new_count),
    .new_elements_i (new_elements),
    .ext_enable_i   (ext_enable),
    .ext_consumed_i (ext_consumed),
    .flush_i        (flush_i),
    .flush_stream_i (flush_stream_i),
    .ext_valid_o    (ext_valid),
    .out_elements_o (out_elements),
    .full_o         (full),
    .empty_o        (empty_o),
    .used_count_o   ()
  );

  iq_issue_select i_issue_select (
    .ext_valid_i    (ext_valid),
    .out_elements_i (out_elements),
    .ext_enable_o   (ext_enable),
    .ext_consumed_o (ext_consumed),
    .issue_valid_o  (issue_valid_o),
    .issue_entry_o  (issue_entry_o)
  );

endmodule

//--- hw/iq_issue_select.sv
`timescale 1ns/10ps
`include "iq_params.svh"

module iq_issue_select
  import iq_pkg::*;
(
  input  logic                              ext_valid_i [`IQ_EXT_COUNT],
  input  iq_entry_t                         out_elements_i [`IQ_EXT_COUNT],
  output logic                              ext_enable_o,
  output logic [$clog2(`IQ_EXT_COUNT)-1:0]  ext_consumed_o,
  output logic                              issue_valid_o [`IQ_EXT_COUNT],
  output iq_entry_t                         issue_entry_o [`IQ_EXT_COUNT]
);

  localparam int EXT   = `IQ_EXT_COUNT;
  localparam int CON_W = $clog2(EXT);
  localparam int NUM_W = CON_W + 1;

  logic [EXT-1:0]   issue_vec;
  logic [NUM_W-1:0] issue_num;

  always_comb begin
    logic stop;
    logic mem_seen;
    logic is_mem;
    stop      = 1'b0;
    mem_seen  = 1'b0;
    is_mem    = 1'b0;
    issue_num = '0;
    issue_vec = '0;
    for (int i = 0; i < EXT; i++) begin
      is_mem = (out_elements_i[i].op == OP_LOAD) || (out_elements_i[i].op == OP_STORE);
      if (stop || !ext_valid_i[i]) begin
        stop = 1'b1;
      end else if (is_mem && mem_seen) begin
        stop = 1'b1;   // a second memory op waits for the next group.
      end else begin
        issue_vec[i] = 1'b1;
        issue_num    = issue_num + NUM_W'(1);
        mem_seen     = mem_seen | is_mem;
        if (out_elements_i[i].op == OP_BRANCH)
          stop = 1'b1;  // nothing younger than a branch goes with it.
      end
    end
  end

  always_comb begin
    for (int i = 0; i < EXT; i++) begin
      issue_valid_o[i] = issue_vec[i];
      issue_entry_o[i] = out_elements_i[i];
    end
  end

  assign ext_enable_o   = issue_vec[0];
  assign ext_consumed_o = CON_W'(issue_num - NUM_W'(1));  // count minus one, as the buffer expects.

  // issued lanes form an unbroken run starting at lane 0.
  always_comb begin
    a_contiguous_issue: assert ((issue_vec & (issue_vec + EXT'(1))) == '0);
  end

endmodule

//--- hw/iq_circ_buf.sv
`timescale 1ns/10ps
`include "iq_params.svh"

module iq_circ_buf
  import iq_pkg::*;
(
  input  logic                              clock,
  input  logic                              reset_n,
  input  logic                              ins_enable_i,
  input  logic [$clog2(`IQ_INS_COUNT)-1:0]  new_count_i,
  input  iq_entry_t                         new_elements_i [`IQ_INS_COUNT],
  input  logic                              ext_enable_i,
  input  logic [$clog2(`IQ_EXT_COUNT)-1:0]  ext_consumed_i,
  input  logic                              flush_i,
  input  logic                              flush_stream_i,
  output logic                              ext_valid_o [`IQ_EXT_COUNT],
  output iq_entry_t                         out_elements_o [`IQ_EXT_COUNT],
  output logic                              full_o,
  output logic                              empty_o,
  output logic [$clog2(`IQ_DEPTH):0]        used_count_o
);

  localparam int DEPTH = `IQ_DEPTH;
  localparam int INS   = `IQ_INS_COUNT;
  localparam int EXT   = `IQ_EXT_COUNT;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam int INS_W = $clog2(INS);

  iq_entry_t          mem [DEPTH];
  logic [PTR_W-1:0]   head_q, tail_q;
  logic [CNT_W-1:0]   used_q;

  logic [PTR_W-1:0]   head_ext, head_nxt, tail_nxt;
  logic [CNT_W-1:0]   cnt_ext, cnt_ins, cnt_nxt;
  logic [CNT_W-1:0]   flush_len;

  always_comb begin
    logic stop;
    logic s;
    head_ext = head_q;
    cnt_ext  = used_q;
    if (ext_enable_i) begin
      head_ext = head_q + PTR_W'(ext_consumed_i) + PTR_W'(1);
      cnt_ext  = used_q - CNT_W'(ext_consumed_i) - CNT_W'(1);
    end

    tail_nxt = tail_q;
    cnt_ins  = cnt_ext;
    if (ins_enable_i) begin
      tail_nxt = tail_q + PTR_W'(new_count_i) + PTR_W'(1);
      cnt_ins  = cnt_ext + CNT_W'(new_count_i) + CNT_W'(1);
    end

    // the flush sees the queue after this edge's extract and insert, so entries
    // past the old occupancy are still on the insert lanes.
    stop      = 1'b0;
    s         = 1'b0;
    flush_len = '0;
    if (flush_i) begin
      for (int k = 0; k < DEPTH; k++) begin
        if (!stop && CNT_W'(k) < cnt_ins) begin
          if (CNT_W'(k) < cnt_ext)
            s = mem[head_ext + PTR_W'(k)].stream;
          else
            s = new_elements_i[INS_W'(CNT_W'(k) - cnt_ext)].stream;
          if (s == flush_stream_i)
            flush_len = flush_len + CNT_W'(1);
          else
            stop = 1'b1;   // first entry of the other stream ends the flush.
        end
      end
    end

    head_nxt = head_ext + PTR_W'(flush_len);
    cnt_nxt  = cnt_ins - flush_len;
  end

  always_ff @(posedge clock) begin
    if (ins_enable_i) begin
      for (int i = 0; i < INS; i++) begin
        if (INS_W'(i) <= new_count_i)
          mem[tail_q + PTR_W'(i)] <= new_elements_i[i];
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head_q <= '0;
      tail_q <= '0;
      used_q <= '0;
    end else begin
      head_q <= head_nxt;
      tail_q <= tail_nxt;
      used_q <= cnt_nxt;
    end
  end

  always_comb begin
    for (int n = 0; n < EXT; n++) begin
      out_elements_o[n] = mem[head_q + PTR_W'(n)];
      ext_valid_o[n]    = (used_q > CNT_W'(n));
    end
  end

  assign full_o       = (used_q > CNT_W'(DEPTH - INS));  // room is always left for one group.
  assign empty_o      = (used_q == '0);
  assign used_count_o = used_q;

  a_no_insert_when_full: assert property (@(posedge clock) disable iff (!reset_n)
    ins_enable_i |-> !full_o);

  a_no_extract_when_empty: assert property (@(posedge clock) disable iff (!reset_n)
    ext_enable_i |-> !empty_o);

  a_extract_within_used: assert property (@(posedge clock) disable iff (!reset_n)
    ext_enable_i |-> (CNT_W'(ext_consumed_i) < used_q));

endmodule

//--- hw/iq_dispatch.sv
`timescale 1ns/10ps
`include "iq_params.svh"

module iq_dispatch
  import iq_pkg::*;
(
  input  logic                              clock,
  input  logic                              reset_n,
  input  logic                              dec_enable_i,
  input  logic [$clog2(`IQ_INS_COUNT)-1:0]  dec_count_i,
  input  logic [31:0]                       dec_pc_i [`IQ_INS_COUNT],
  input  logic [31:0]                       dec_inst_i [`IQ_INS_COUNT],
  input  logic                              dec_stream_i [`IQ_INS_COUNT],
  input  logic                              full_i,
  output logic                              stall_o,
  output logic                              ins_enable_o,
  output logic [$clog2(`IQ_INS_COUNT)-1:0]  new_count_o,
  output iq_entry_t                         new_elements_o [`IQ_INS_COUNT]
);

  localparam int INS = `IQ_INS_COUNT;

  logic [ROB_SLOT_W-1:0] slot_q;   // slot given to lane 0 of the next accepted group.

  function automatic op_class_e classify(input logic [31:0] inst);
    op_class_e op;
    case (inst[6:0])
      OPC_LOAD:   op = OP_LOAD;
      OPC_STORE:  op = OP_STORE;
      OPC_BRANCH: op = OP_BRANCH;
      default:    op = OP_ALU;
    endcase
    return op;
  endfunction

  // decode holds its group while the queue is near full.
  assign stall_o      = full_i;
  assign ins_enable_o = dec_enable_i & ~full_i;
  assign new_count_o  = dec_count_i;

  always_comb begin
    for (int i = 0; i < INS; i++) begin
      new_elements_o[i].pc        = dec_pc_i[i];
      new_elements_o[i].inst_word = dec_inst_i[i];
      new_elements_o[i].rob_slot  = slot_q + ROB_SLOT_W'(i);  // lanes get consecutive slots.
      new_elements_o[i].stream    = dec_stream_i[i];
      new_elements_o[i].op        = classify(dec_inst_i[i]);
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      slot_q <= '0;
    end else if (ins_enable_o) begin
      slot_q <= slot_q + ROB_SLOT_W'(dec_count_i) + ROB_SLOT_W'(1);  // wraps at the rob depth.
    end
  end

endmodule

//--- hw/iq_pkg.sv
`include "iq_params.svh"

package iq_pkg;

  localparam int ROB_SLOT_W = $clog2(`IQ_ROB_DEPTH);

  // operation class carried with every queue entry.
  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_BRANCH = 2'd3
  } op_class_e;

  // major opcodes that select a class other than alu.
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef struct packed {
    logic [31:0]           pc;
    logic [31:0]           inst_word;
    logic [ROB_SLOT_W-1:0] rob_slot;
    logic                  stream;     // hardware thread that owns the entry.
    op_class_e             op;
  } iq_entry_t;

endpackage

//--- hw/iq_params.svh
`ifndef IQ_PARAMS_SVH
`define IQ_PARAMS_SVH

// number of entries held in the instruction queue.
`define IQ_DEPTH 16

// widest decode group accepted in one cycle.
`define IQ_INS_COUNT 4

// widest issue group leaving the queue in one cycle.
`define IQ_EXT_COUNT 4

// reorder-buffer slots, a power of two so the slot counter wraps by itself.
`define IQ_ROB_DEPTH 32

`endif
